// File: rv32m_types_pkg.sv
package rv32m_types_pkg;

    typedef logic [31:0] word_t;

    // Major opcodes of RV32I. The M extension lives in the register-register group.
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } opcode_t;

    // Bit 2 separates the divide group from the multiply group.
    typedef enum logic [2:0] {
        mult_div_f3_mul    = 3'b000,
        mult_div_f3_mulh   = 3'b001,
        mult_div_f3_mulhsu = 3'b010,
        mult_div_f3_mulhu  = 3'b011,
        mult_div_f3_div    = 3'b100,
        mult_div_f3_divu   = 3'b101,
        mult_div_f3_rem    = 3'b110,
        mult_div_f3_remu   = 3'b111
    } muldiv_f3_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } decode_info_t;

    localparam logic [6:0] funct7_muldiv = 7'b0000001;

endpackage : rv32m_types_pkg

// File: muldiv_cfg_pkg.sv
package muldiv_cfg_pkg;

    // The physical register file of the core has 64 entries.
    localparam int unsigned phys_reg_bits = 6;

    typedef logic [phys_reg_bits-1:0] phys_reg_t;

    // One iteration per bit of the sign-extended 33-bit dividend.
    localparam int unsigned div_steps = 33;

    localparam int unsigned div_cnt_bits = $clog2(div_steps + 1);

    typedef logic [div_cnt_bits-1:0] div_cnt_t;

    typedef struct packed {
        phys_reg_t              tag;
        rv32m_types_pkg::word_t value;
    } result_t;

endpackage : muldiv_cfg_pkg

// File: div_core_seq.sv
module div_core_seq (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [32:0] a,
    input  logic [32:0] b,
    output logic        complete,
    output logic [32:0] quotient,
    output logic [32:0] remainder
);

    logic [32:0] a_mag;
    logic [32:0] b_mag;

    logic [32:0] quo_q;      // Dividend shifts out of the top while quotient bits enter below.
    logic [32:0] rem_q;
    logic [32:0] dvs_q;
    logic        neg_quo_q;
    logic        neg_rem_q;

    muldiv_cfg_pkg::div_cnt_t cnt_q;

    logic [33:0] shifted;
    logic [34:0] trial;

    assign a_mag = a[32] ? (~a + 33'd1) : a;
    assign b_mag = b[32] ? (~b + 33'd1) : b;

    assign shifted = {rem_q, quo_q[32]};
    assign trial   = {1'b0, shifted} - {2'b00, dvs_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q    <= '0;
            complete <= 1'b0;
        end else if (start) begin
            cnt_q    <= muldiv_cfg_pkg::div_cnt_t'(muldiv_cfg_pkg::div_steps);
            complete <= 1'b0;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == muldiv_cfg_pkg::div_cnt_t'(1)) begin
                complete <= 1'b1;  // Held until the next start.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q     <= a_mag;
            rem_q     <= '0;
            dvs_q     <= b_mag;
            neg_quo_q <= a[32] ^ b[32];
            neg_rem_q <= a[32];
        end else if (cnt_q != '0) begin
            if (trial[34]) begin
                rem_q <= shifted[32:0];  // Borrow, so the partial remainder is restored.
                quo_q <= {quo_q[31:0], 1'b0};
            end else begin
                rem_q <= trial[32:0];
                quo_q <= {quo_q[31:0], 1'b1};
            end
        end
    end

    // The quotient is negative when the signs differ; the remainder follows the dividend.
    always_comb begin
        quotient  = neg_quo_q ? (~quo_q + 33'd1) : quo_q;
        remainder = neg_rem_q ? (~rem_q + 33'd1) : rem_q;
    end

endmodule : div_core_seq

// File: fu_div_rem.sv
module fu_div_rem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  rv32m_types_pkg::muldiv_f3_t funct3,
    input  rv32m_types_pkg::word_t      rs1_v,
    input  rv32m_types_pkg::word_t      rs2_v,
    output rv32m_types_pkg::word_t      rd_v,
    output logic                        valid
);

    rv32m_types_pkg::muldiv_f3_t f3_q;
    rv32m_types_pkg::word_t      dividend_q;
    logic                        div_zero_q;

    logic        is_signed;
    logic [32:0] core_a;
    logic [32:0] core_b;
    logic        complete;
    logic        complete_q;
    logic [32:0] quotient;
    logic [32:0] remainder;

    assign is_signed = (funct3 == rv32m_types_pkg::mult_div_f3_div) ||
                       (funct3 == rv32m_types_pkg::mult_div_f3_rem);

    assign core_a = is_signed ? {rs1_v[31], rs1_v} : {1'b0, rs1_v};
    assign core_b = is_signed ? {rs2_v[31], rs2_v} : {1'b0, rs2_v};

    always_ff @(posedge clk) begin
        if (start) begin
            f3_q       <= funct3;
            dividend_q <= rs1_v;
            div_zero_q <= (rs2_v == '0);
        end
    end

    div_core_seq div_core0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .a         (core_a),
        .b         (core_b),
        .complete  (complete),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            complete_q <= 1'b0;
        end else begin
            complete_q <= complete;
        end
    end

    assign valid = complete & ~complete_q;  // One pulse on the rising edge of complete.

    always_comb begin
        unique case (f3_q)
            rv32m_types_pkg::mult_div_f3_div,
            rv32m_types_pkg::mult_div_f3_divu: begin
                rd_v = div_zero_q ? '1 : quotient[31:0];
            end
            rv32m_types_pkg::mult_div_f3_rem,
            rv32m_types_pkg::mult_div_f3_remu: begin
                rd_v = div_zero_q ? dividend_q : remainder[31:0];
            end
            default: begin
                rd_v = '0;
            end
        endcase
    end

endmodule : fu_div_rem

// File: fu_mul.sv
module fu_mul (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  rv32m_types_pkg::muldiv_f3_t funct3,
    input  rv32m_types_pkg::word_t      rs1_v,
    input  rv32m_types_pkg::word_t      rs2_v,
    input  muldiv_cfg_pkg::phys_reg_t   tag,
    output logic                        valid,
    output muldiv_cfg_pkg::result_t     result
);

    logic a_signed;
    logic b_signed;

    logic signed [32:0]        op_a_s1;
    logic signed [32:0]        op_b_s1;
    logic                      hi_s1;
    muldiv_cfg_pkg::phys_reg_t tag_s1;
    logic                      valid_s1;

    logic signed [65:0]        prod_s2;
    logic                      hi_s2;
    muldiv_cfg_pkg::phys_reg_t tag_s2;
    logic                      valid_s2;

    assign a_signed = (funct3 == rv32m_types_pkg::mult_div_f3_mulh) ||
                      (funct3 == rv32m_types_pkg::mult_div_f3_mulhsu);
    assign b_signed = (funct3 == rv32m_types_pkg::mult_div_f3_mulh);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= start;
            valid_s2 <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        op_a_s1 <= {a_signed & rs1_v[31], rs1_v};
        op_b_s1 <= {b_signed & rs2_v[31], rs2_v};
        hi_s1   <= (funct3 != rv32m_types_pkg::mult_div_f3_mul);
        tag_s1  <= tag;
    end

    // The low word of MUL does not depend on the extension of the operands.
    always_ff @(posedge clk) begin
        prod_s2 <= op_a_s1 * op_b_s1;
        hi_s2   <= hi_s1;
        tag_s2  <= tag_s1;
    end

    always_comb begin
        result.tag   = tag_s2;
        result.value = hi_s2 ? prod_s2[63:32] : prod_s2[31:0];
    end

    assign valid = valid_s2;

endmodule : fu_mul

// File: muldiv_unit.sv
module muldiv_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue,
    input  rv32m_types_pkg::decode_info_t decode_info,
    input  rv32m_types_pkg::word_t        rs1_v,
    input  rv32m_types_pkg::word_t        rs2_v,
    input  muldiv_cfg_pkg::phys_reg_t     rd_tag,
    output logic                          div_busy,
    output logic                          wb_valid,
    output muldiv_cfg_pkg::result_t       wb
);

    rv32m_types_pkg::muldiv_f3_t f3;

    logic is_m;
    logic mul_start;
    logic div_start;

    logic                    mul_valid;
    muldiv_cfg_pkg::result_t mul_result;
    logic                    div_valid;
    rv32m_types_pkg::word_t  div_rd_v;

    muldiv_cfg_pkg::phys_reg_t div_tag_q;
    logic                      div_busy_q;
    logic                      park_valid_q;
    rv32m_types_pkg::word_t    park_value_q;
    logic                      div_leaves;

    assign f3 = rv32m_types_pkg::muldiv_f3_t'(decode_info.funct3);

    assign is_m = issue &&
                  (decode_info.opcode == rv32m_types_pkg::op_b_reg) &&
                  (decode_info.funct7 == rv32m_types_pkg::funct7_muldiv);

    assign mul_start = is_m & ~decode_info.funct3[2];
    assign div_start = is_m & decode_info.funct3[2];

    fu_mul mul0 (
        .clk    (clk),
        .rst    (rst),
        .start  (mul_start),
        .funct3 (f3),
        .rs1_v  (rs1_v),
        .rs2_v  (rs2_v),
        .tag    (rd_tag),
        .valid  (mul_valid),
        .result (mul_result)
    );

    fu_div_rem div0 (
        .clk    (clk),
        .rst    (rst),
        .start  (div_start),
        .funct3 (f3),
        .rs1_v  (rs1_v),
        .rs2_v  (rs2_v),
        .rd_v   (div_rd_v),
        .valid  (div_valid)
    );

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_tag_q <= rd_tag;
        end
        if (div_valid && mul_valid) begin
            park_value_q <= div_rd_v;  // Multiply owns the port this cycle.
        end
    end

    assign div_leaves = ~mul_valid & (park_valid_q | div_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            park_valid_q <= 1'b0;
            div_busy_q   <= 1'b0;
        end else begin
            if (div_valid && mul_valid) begin
                park_valid_q <= 1'b1;
            end else if (park_valid_q && !mul_valid) begin
                park_valid_q <= 1'b0;
            end
            if (div_start) begin
                div_busy_q <= 1'b1;
            end else if (div_leaves) begin
                div_busy_q <= 1'b0;
            end
        end
    end

    assign div_busy = div_busy_q;

    always_comb begin
        wb_valid = 1'b1;
        wb       = '0;
        if (mul_valid) begin
            wb = mul_result;
        end else if (park_valid_q) begin
            wb.tag   = div_tag_q;
            wb.value = park_value_q;
        end else if (div_valid) begin
            wb.tag   = div_tag_q;
            wb.value = div_rd_v;
        end else begin
            wb_valid = 1'b0;
        end
    end

endmodule : muldiv_unit

// File: tb_muldiv_unit.sv
module tb_muldiv_unit;

    typedef struct packed {
        int                      cyc;
        muldiv_cfg_pkg::result_t res;
    } expect_t;

    localparam int mul_latency = 2;
    localparam int div_latency = muldiv_cfg_pkg::div_steps + 1;
    localparam int total_issues = 4 * 25 + 4 * 20 + 4 * 12 + 10 + 4 + 4;
    localparam int watchdog_cycles = total_issues * 40 + 500;

    logic                          clk;
    logic                          rst;
    logic                          issue;
    rv32m_types_pkg::decode_info_t decode_info;
    rv32m_types_pkg::word_t        rs1_v;
    rv32m_types_pkg::word_t        rs2_v;
    muldiv_cfg_pkg::phys_reg_t     rd_tag;
    logic                          div_busy;
    logic                          wb_valid;
    muldiv_cfg_pkg::result_t       wb;

    int                        seed;
    int                        cycle;
    int                        test_errors;
    int                        tests_passed;
    int                        tests_failed;
    muldiv_cfg_pkg::phys_reg_t next_tag;
    expect_t                   exp_q[$];
    muldiv_cfg_pkg::result_t   got_q[$];
    int                        got_cyc_q[$];

    muldiv_unit dut0 (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .decode_info (decode_info),
        .rs1_v       (rs1_v),
        .rs2_v       (rs2_v),
        .rd_tag      (rd_tag),
        .div_busy    (div_busy),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial cycle = 0;
    always @(posedge clk) cycle <= cycle + 1;

    // Every written-back result is logged with the cycle it appeared in.
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            got_q.push_back(wb);
            got_cyc_q.push_back(cycle);
        end
    end

    initial begin
        #(watchdog_cycles * 40);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("** FAIL **");
        $finish;
    end

    task automatic expected_result(input rv32m_types_pkg::muldiv_f3_t f3,
                                   input rv32m_types_pkg::word_t a,
                                   input rv32m_types_pkg::word_t b,
                                   input muldiv_cfg_pkg::phys_reg_t tag,
                                   output muldiv_cfg_pkg::result_t res);
        logic [63:0]        prod_ss;
        logic [63:0]        prod_su;
        logic [63:0]        prod_uu;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        logic               ovf;
        sa      = a;
        sb      = b;
        ovf     = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        prod_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        prod_su = {{32{a[31]}}, a} * {32'd0, b};
        prod_uu = {32'd0, a} * {32'd0, b};
        sq      = '1;  // Division by zero gives all ones and the dividend.
        sr      = a;
        if (ovf) begin
            sq = a;
            sr = '0;
        end else if (b != '0) begin
            sq = sa / sb;
            sr = sa % sb;
        end
        res.tag = tag;
        case (f3)
            rv32m_types_pkg::mult_div_f3_mul:    res.value = prod_uu[31:0];
            rv32m_types_pkg::mult_div_f3_mulh:   res.value = prod_ss[63:32];
            rv32m_types_pkg::mult_div_f3_mulhsu: res.value = prod_su[63:32];
            rv32m_types_pkg::mult_div_f3_mulhu:  res.value = prod_uu[63:32];
            rv32m_types_pkg::mult_div_f3_div:    res.value = sq;
            rv32m_types_pkg::mult_div_f3_divu:   res.value = (b == '0) ? '1 : a / b;
            rv32m_types_pkg::mult_div_f3_rem:    res.value = sr;
            default:                             res.value = (b == '0) ? a : a % b;
        endcase
    endtask

    function automatic rv32m_types_pkg::decode_info_t pack_decode(
            input rv32m_types_pkg::opcode_t op, input logic [2:0] f3, input logic [6:0] f7);
        rv32m_types_pkg::decode_info_t d;
        d.opcode = op;
        d.funct3 = f3;
        d.funct7 = f7;
        return d;
    endfunction

    task automatic compare_result(input string name, input muldiv_cfg_pkg::result_t exp,
                                  input muldiv_cfg_pkg::result_t act);
        if (exp !== act) begin
            $display("** Error %s: expected tag %0d value %08h, actual tag %0d value %08h",
                     name, exp.tag, exp.value, act.tag, act.value);
            test_errors++;
        end
    endtask

    task automatic compare_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("Test %s passed", name);
            tests_passed++;
        end else begin
            $display("Test %s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // Drives one issue for a single cycle; called a few units after a rising edge.
    task automatic drive_raw(input rv32m_types_pkg::decode_info_t d,
                             input rv32m_types_pkg::word_t a, input rv32m_types_pkg::word_t b);
        issue       = 1'b1;
        decode_info = d;
        rs1_v       = a;
        rs2_v       = b;
        rd_tag      = next_tag;
        next_tag    = next_tag + 1'b1;
        @(posedge clk);
        #4;
        issue = 1'b0;
    endtask

    task automatic drive_issue(input rv32m_types_pkg::muldiv_f3_t f3,
                               input rv32m_types_pkg::word_t a, input rv32m_types_pkg::word_t b,
                               input int latency);
        expect_t e;
        expected_result(f3, a, b, next_tag, e.res);
        e.cyc = cycle + latency;
        exp_q.push_back(e);
        drive_raw(pack_decode(rv32m_types_pkg::op_b_reg, f3, rv32m_types_pkg::funct7_muldiv),
                  a, b);
    endtask

    // Waits for all expected results, then matches each one by its writeback cycle.
    task automatic check_results(input string name, input int max_cycles);
        int waited;
        int hit;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < max_cycles) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);
        #4;
        if (got_q.size() != exp_q.size()) begin
            $display("%s: expected %0d writebacks but saw %0d",
                     name, exp_q.size(), got_q.size());
            test_errors++;
        end
        foreach (exp_q[i]) begin
            hit = -1;
            for (int j = 0; j < got_q.size(); j++) begin
                if (got_cyc_q[j] == exp_q[i].cyc) hit = j;
            end
            if (hit < 0) begin
                $display("%s: no writeback in cycle %0d for tag %0d",
                         name, exp_q[i].cyc, exp_q[i].res.tag);
                test_errors++;
            end else begin
                compare_result(name, exp_q[i].res, got_q[hit]);
            end
        end
        exp_q.delete();
        got_q.delete();
        got_cyc_q.delete();
    endtask

    // Busy must hold from the cycle after issue up to the writeback, then drop.
    task automatic run_div(input string name, input rv32m_types_pkg::muldiv_f3_t f3,
                           input rv32m_types_pkg::word_t a, input rv32m_types_pkg::word_t b);
        int waited;
        drive_issue(f3, a, b, div_latency);
        waited = 0;
        do begin
            @(negedge clk);
            compare_level({name, " busy"}, 1'b1, div_busy);
            waited++;
        end while (!wb_valid && waited < div_latency + 10);
        @(negedge clk);
        compare_level({name, " busy after"}, 1'b0, div_busy);
        @(posedge clk);
        #4;
        check_results(name, 10);
    endtask

    task automatic test_reset();
        compare_level("reset wb_valid", 1'b0, wb_valid);
        compare_level("reset div_busy", 1'b0, div_busy);
        finish_test("reset");
    endtask

    task automatic test_mul();
        rv32m_types_pkg::word_t corners[5];
        rv32m_types_pkg::word_t a;
        rv32m_types_pkg::word_t b;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        for (int f = 0; f < 4; f++) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    drive_issue(rv32m_types_pkg::muldiv_f3_t'(f), corners[i], corners[j],
                                mul_latency);
                end
            end
        end
        check_results("mul corners", 10);
        for (int k = 0; k < 20; k++) begin
            a = $random(seed);
            b = $random(seed);
            for (int f = 0; f < 4; f++) begin
                drive_issue(rv32m_types_pkg::muldiv_f3_t'(f), a, b, mul_latency);
            end
        end
        check_results("mul random", 10);
        finish_test("mul");
    endtask

    task automatic test_div();
        rv32m_types_pkg::word_t dvd[4];
        rv32m_types_pkg::word_t dvs[4];
        dvd = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_fff9, 32'hffff_ff9c};
        dvs = '{32'h0000_0003, 32'h0000_0007, 32'h0000_0002, 32'hffff_fff9};
        for (int f = 4; f < 8; f++) begin
            for (int k = 0; k < 4; k++) begin
                run_div("div corner", rv32m_types_pkg::muldiv_f3_t'(f), dvd[k], dvs[k]);
            end
            for (int k = 0; k < 8; k++) begin
                run_div("div random", rv32m_types_pkg::muldiv_f3_t'(f), $random(seed),
                        (k < 4) ? $random(seed) : $random(seed) % 1000);
            end
        end
        finish_test("div");
    endtask

    task automatic test_special();
        for (int f = 4; f < 8; f++) begin
            run_div("div by zero", rv32m_types_pkg::muldiv_f3_t'(f), 32'h1234_5678, '0);
            run_div("div by zero", rv32m_types_pkg::muldiv_f3_t'(f), 32'h8000_0000, '0);
        end
        run_div("overflow div", rv32m_types_pkg::mult_div_f3_div, 32'h8000_0000, '1);
        run_div("overflow rem", rv32m_types_pkg::mult_div_f3_rem, 32'h8000_0000, '1);
        finish_test("special");
    endtask

    // The multiply lands in the divide's writeback cycle, so the divide leaves one cycle late.
    task automatic run_collision(input rv32m_types_pkg::muldiv_f3_t div_f3,
                                 input rv32m_types_pkg::muldiv_f3_t mul_f3);
        drive_issue(div_f3, $random(seed), $random(seed), div_latency + 1);
        repeat (div_latency - mul_latency - 1) @(posedge clk);
        #4;
        drive_issue(mul_f3, $random(seed), $random(seed), mul_latency);
        repeat (2) @(posedge clk);
        #4;
        compare_level("collision busy", 1'b1, div_busy);
        check_results("collision", 10);
        compare_level("collision busy after", 1'b0, div_busy);
    endtask

    task automatic test_collision();
        run_collision(rv32m_types_pkg::mult_div_f3_div, rv32m_types_pkg::mult_div_f3_mul);
        run_collision(rv32m_types_pkg::mult_div_f3_remu, rv32m_types_pkg::mult_div_f3_mulhu);
        finish_test("collision");
    endtask

    task automatic test_filter();
        drive_raw(pack_decode(rv32m_types_pkg::op_b_reg, 3'b000, 7'b0000000), 32'd3, 32'd5);
        compare_level("filter busy", 1'b0, div_busy);
        drive_raw(pack_decode(rv32m_types_pkg::op_b_reg, 3'b100, 7'b0100000), 32'd9, 32'd2);
        compare_level("filter busy", 1'b0, div_busy);
        drive_raw(pack_decode(rv32m_types_pkg::op_b_imm, 3'b001, 7'b0000001), 32'd7, 32'd7);
        compare_level("filter busy", 1'b0, div_busy);
        drive_raw(pack_decode(rv32m_types_pkg::op_b_load, 3'b110, 7'b0000001), 32'd8, 32'd3);
        compare_level("filter busy", 1'b0, div_busy);
        repeat (40) @(posedge clk);
        #4;
        check_results("filter", 0);
        finish_test("filter");
    endtask

    initial begin
        seed         = 48762;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        next_tag     = '0;
        rst          = 1'b1;
        issue        = 1'b0;
        decode_info  = '0;
        rs1_v        = '0;
        rs2_v        = '0;
        rd_tag       = '0;
        repeat (10) @(posedge clk);
        #4;
        rst = 1'b0;
        test_reset();
        test_mul();
        test_div();
        test_special();
        test_collision();
        test_filter();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_muldiv_unit

// File: verilog.f
rv32m_types_pkg.sv
muldiv_cfg_pkg.sv
div_core_seq.sv
fu_div_rem.sv
fu_mul.sv
muldiv_unit.sv
tb_muldiv_unit.sv

// File: Bender.yml
package:
  name: muldiv_unit

sources:
  - rv32m_types_pkg.sv
  - muldiv_cfg_pkg.sv
  - div_core_seq.sv
  - fu_div_rem.sv
  - fu_mul.sv
  - muldiv_unit.sv
  - target: test
    files:
      - tb_muldiv_unit.sv
